// ==== source/pong_config.svh ====
// screen geometry, sync positions and object sizes for pong
// also ball and paddle speeds, start positions and serve delay
`ifndef PONG_CONFIG_SVH
`define PONG_CONFIG_SVH

// coordinates
`define PONG_CORDW        10   // bits per screen coordinate
`define PONG_H_RES        640  // active columns
`define PONG_V_RES        480  // active lines
`define PONG_H_FULL       800  // columns incl. blanking
`define PONG_V_FULL       525  // lines incl. blanking
`define PONG_HS_START     656  // first hsync column
`define PONG_HS_END       751  // last hsync column
`define PONG_VS_START     490  // first vsync line
`define PONG_VS_END       491  // last vsync line

// ball
`define PONG_B_SIZE       8    // square side in pixels
`define PONG_B_SPX        2    // horizontal step per frame
`define PONG_B_SPY        1    // vertical step per frame
`define PONG_B_X0         300  // start column
`define PONG_B_Y0         2    // start row

// paddles
`define PONG_P_H          40   // height in pixels
`define PONG_P_W          10   // width in pixels
`define PONG_P_SP         1    // step per frame
`define PONG_P_OFFS       32   // gap to the screen edge
`define PONG_P_Y0         220  // start row

`define PONG_SERVE_FRAMES 2    // frames held still after reset
`endif

// ==== source/pong_pkg.sv ====
// shared pong types
// coordinate, per-pixel timing, object position and colour structs
`include "pong_config.svh"

package pong_pkg;

    // one screen coordinate, column or row
    typedef logic [`PONG_CORDW-1:0] coord_t;

    // screen position and raw sync state for one pixel clock
    typedef struct packed {
        coord_t sx;     // column
        coord_t sy;     // line
        logic   hsync;  // high inside the pulse
        logic   vsync;  // high inside the pulse
        logic   de;     // active picture area
    } timing_t;

    // top-left corner of a drawn object
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // 12-bit colour
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // one registered output pixel
    typedef struct packed {
        logic hsync;  // active low at the pins
        logic vsync;  // active low at the pins
        logic de;
        rgb_t rgb;
    } video_t;

endpackage

// ==== source/display_timings.sv ====
// 640x480 display timing generator
// column and line counters with sync and data enable decode
`timescale 1ns/100ps
`include "pong_config.svh"

module display_timings (
    input  logic              clk_pix,
    input  logic              arst_n,
    output pong_pkg::timing_t timing
);
    import pong_pkg::*;

    localparam coord_t H_LAST   = coord_t'(`PONG_H_FULL - 1);  // 799
    localparam coord_t V_LAST   = coord_t'(`PONG_V_FULL - 1);  // 524
    localparam coord_t H_ACTIVE = coord_t'(`PONG_H_RES);
    localparam coord_t V_ACTIVE = coord_t'(`PONG_V_RES);
    localparam coord_t HS_START = coord_t'(`PONG_HS_START);
    localparam coord_t HS_END   = coord_t'(`PONG_HS_END);
    localparam coord_t VS_START = coord_t'(`PONG_VS_START);
    localparam coord_t VS_END   = coord_t'(`PONG_VS_END);

    coord_t sx;  // current column
    coord_t sy;  // current line

    // column counter, line advances on column wrap
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (sx == H_LAST) begin
                sx <= '0;  // end of line
                if (sy == V_LAST) begin
                    sy <= '0;  // end of frame
                end else begin
                    sy <= sy + 1'b1;
                end
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // decode straight from the counters
    always_comb begin
        timing.sx    = sx;
        timing.sy    = sy;
        timing.hsync = (sx >= HS_START) && (sx <= HS_END);  // logical pulse
        timing.vsync = (sy >= VS_START) && (sy <= VS_END);
        timing.de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);  // visible area
    end

endmodule

// ==== source/game_control.sv ====
// game control
// one-cycle frame tick at the start of vertical blanking, serve delay
`timescale 1ns/100ps
`include "pong_config.svh"

module game_control (
    input  logic              clk_pix,
    input  logic              arst_n,
    input  pong_pkg::timing_t timing,
    output logic              frame_tick,
    output logic              play
);

    // counter wide enough for the serve frame count
    localparam int SERVE_W = ($clog2(`PONG_SERVE_FRAMES + 1) > 0) ?
                             $clog2(`PONG_SERVE_FRAMES + 1) : 1;
    localparam logic [SERVE_W-1:0] SERVE_LAST = SERVE_W'(`PONG_SERVE_FRAMES - 1);

    logic               blank_start;  // first pixel of vertical blanking
    logic [SERVE_W-1:0] serve_cnt;    // ticks seen while held

    // sx 0 on the first line below the picture
    assign blank_start = (timing.sx == '0) && (timing.sy == `PONG_CORDW'(`PONG_V_RES));

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            frame_tick <= 1'b0;
        end else begin
            frame_tick <= blank_start;  // one cycle per frame
        end
    end

    // hold the game still for the serve frames, then release for good
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            serve_cnt <= '0;
            play      <= 1'b0;
        end else if (frame_tick && !play) begin
            if (serve_cnt == SERVE_LAST) begin
                play <= 1'b1;  // last held tick, motion from the next one
            end else begin
                serve_cnt <= serve_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/ball_motion.sv ====
// ball position and direction with bounce on all four screen edges
// updated once per frame while the game is in play
`timescale 1ns/100ps
`include "pong_config.svh"

module ball_motion (
    input  logic           clk_pix,
    input  logic           arst_n,
    input  logic           frame_tick,
    input  logic           play,
    output pong_pkg::pos_t ball
);
    import pong_pkg::*;

    localparam coord_t SPX    = coord_t'(`PONG_B_SPX);
    localparam coord_t SPY    = coord_t'(`PONG_B_SPY);
    localparam coord_t X_EDGE = coord_t'(`PONG_H_RES - (`PONG_B_SPX + `PONG_B_SIZE));
    localparam coord_t Y_EDGE = coord_t'(`PONG_V_RES - (`PONG_B_SPY + `PONG_B_SIZE));

    coord_t bx;   // left column
    coord_t by;   // top row
    logic   dx;   // 1 moving left
    logic   dy;   // 1 moving up
    logic   step; // move this cycle

    assign step = frame_tick && play;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            bx <= coord_t'(`PONG_B_X0);
            by <= coord_t'(`PONG_B_Y0);
            dx <= 1'b0;  // start right
            dy <= 1'b0;  // and down
        end else if (step) begin
            // horizontal
            if (bx >= X_EDGE) begin  // right edge
                dx <= 1'b1;
                bx <= bx - SPX;
            end else if (bx < SPX) begin  // left edge
                dx <= 1'b0;
                bx <= bx + SPX;
            end else begin
                bx <= dx ? bx - SPX : bx + SPX;
            end

            // vertical
            if (by >= Y_EDGE) begin  // bottom edge
                dy <= 1'b1;
                by <= by - SPY;
            end else if (by < SPY) begin  // top edge
                dy <= 1'b0;
                by <= by + SPY;
            end else begin
                by <= dy ? by - SPY : by + SPY;
            end
        end
    end

    assign ball.x = bx;
    assign ball.y = by;

endmodule

// ==== source/paddle_ai.sv ====
// "AI" paddle that follows the ball centre
// one step per frame, kept inside the screen
`timescale 1ns/100ps
`include "pong_config.svh"

module paddle_ai (
    input  logic             clk_pix,
    input  logic             arst_n,
    input  logic             frame_tick,
    input  logic             play,
    input  pong_pkg::pos_t   ball,
    output pong_pkg::coord_t paddle_y
);
    import pong_pkg::*;

    localparam coord_t P_SP    = coord_t'(`PONG_P_SP);
    localparam coord_t HALF_SP = coord_t'(`PONG_P_SP / 2);  // dead band
    localparam coord_t Y_LIMIT = coord_t'(`PONG_V_RES - (`PONG_P_H + `PONG_P_SP / 2));

    coord_t p_mid;    // paddle centre row
    coord_t b_mid;    // ball centre row
    logic   go_down;
    logic   go_up;

    // ball value before this tick's ball update
    assign p_mid = paddle_y + coord_t'(`PONG_P_H / 2);
    assign b_mid = ball.y + coord_t'(`PONG_B_SIZE / 2);

    // half-step dead band either side of the ball centre
    assign go_down = (p_mid + HALF_SP) < b_mid;
    assign go_up   = p_mid > (b_mid + HALF_SP);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            paddle_y <= coord_t'(`PONG_P_Y0);
        end else if (frame_tick && play) begin
            if (go_down) begin
                if (paddle_y < Y_LIMIT) begin  // stop at screen bottom
                    paddle_y <= paddle_y + P_SP;
                end
            end else if (go_up) begin
                if (paddle_y > P_SP) begin  // stop at screen top
                    paddle_y <= paddle_y - P_SP;
                end
            end
        end
    end

endmodule

// ==== source/pixel_compose.sv ====
// object hit tests and colour select
// registered sync, data enable and rgb out
`timescale 1ns/100ps
`include "pong_config.svh"

module pixel_compose (
    input  logic              clk_pix,
    input  logic              arst_n,
    input  pong_pkg::timing_t timing,
    input  pong_pkg::pos_t    ball,
    input  pong_pkg::coord_t  paddle_l,
    input  pong_pkg::coord_t  paddle_r,
    output pong_pkg::video_t  video
);
    import pong_pkg::*;

    localparam coord_t L_X0 = coord_t'(`PONG_P_OFFS);                             // left paddle
    localparam coord_t L_X1 = coord_t'(`PONG_P_OFFS + `PONG_P_W);
    localparam coord_t R_X0 = coord_t'(`PONG_H_RES - `PONG_P_OFFS - `PONG_P_W);   // right paddle
    localparam coord_t R_X1 = coord_t'(`PONG_H_RES - `PONG_P_OFFS);

    logic ball_hit;
    logic left_hit;
    logic right_hit;
    rgb_t colour;     // next pixel colour

    always_comb begin
        ball_hit  = (timing.sx >= ball.x) && (timing.sx < ball.x + coord_t'(`PONG_B_SIZE))
                 && (timing.sy >= ball.y) && (timing.sy < ball.y + coord_t'(`PONG_B_SIZE));
        left_hit  = (timing.sx >= L_X0) && (timing.sx < L_X1)
                 && (timing.sy >= paddle_l) && (timing.sy < paddle_l + coord_t'(`PONG_P_H));
        right_hit = (timing.sx >= R_X0) && (timing.sx < R_X1)
                 && (timing.sy >= paddle_r) && (timing.sy < paddle_r + coord_t'(`PONG_P_H));
        // white objects on black, nothing outside the picture
        colour = (timing.de && (ball_hit || left_hit || right_hit)) ? '1 : '0;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            video.hsync <= 1'b1;  // inactive
            video.vsync <= 1'b1;
            video.de    <= 1'b0;
            video.rgb   <= '0;
        end else begin
            video.hsync <= ~timing.hsync;  // 480p syncs are active low
            video.vsync <= ~timing.vsync;
            video.de    <= timing.de;
            video.rgb   <= colour;
        end
    end

endmodule

// ==== source/pong_top.sv ====
// pong top level
// timing, game control, ball, two paddles and pixel output
`timescale 1ns/100ps

module pong_top (
    input  logic       clk_pix,
    input  logic       arst_n,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);
    import pong_pkg::*;

    timing_t timing;      // current counter position
    logic    frame_tick;  // start of vertical blanking
    logic    play;        // serve delay over
    pos_t    ball;
    coord_t  paddle_l;
    coord_t  paddle_r;
    video_t  video;       // registered pixel

    display_timings display_timings_i (
        .clk_pix, .arst_n, .timing
    );

    game_control game_control_i (
        .clk_pix, .arst_n, .timing, .frame_tick, .play
    );

    ball_motion ball_motion_i (
        .clk_pix, .arst_n, .frame_tick, .play, .ball
    );

    paddle_ai paddle_left_i (
        .clk_pix, .arst_n, .frame_tick, .play, .ball, .paddle_y(paddle_l)
    );

    paddle_ai paddle_right_i (
        .clk_pix, .arst_n, .frame_tick, .play, .ball, .paddle_y(paddle_r)
    );

    pixel_compose pixel_compose_i (
        .clk_pix, .arst_n, .timing, .ball, .paddle_l, .paddle_r, .video
    );

    // break the pixel struct out to the pins
    assign hsync = video.hsync;
    assign vsync = video.vsync;
    assign de    = video.de;
    assign r     = video.rgb.r;
    assign g     = video.rgb.g;
    assign b     = video.rgb.b;

endmodule

// ==== verif/pong_clk_gen.sv ====
// pixel clock and power-on reset for the pong testbench
`timescale 1ns/100ps

module pong_clk_gen #(
    parameter int RESET_CYCLES = 16  // clocks held in reset
) (
    output logic clk_pix,
    output logic rst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_pix);
        @(negedge clk_pix);
        rst_n <= 1'b1;  // release on a falling edge
    end

endmodule

// ==== verif/pong_properties.sv ====
// concurrent checks on pong video outputs and game control
// bound into pong_top
`timescale 1ns/100ps

module pong_properties (
    input logic       clk_pix,
    input logic       arst_n,
    input logic       hsync,
    input logic       vsync,
    input logic       de,
    input logic [3:0] r,
    input logic [3:0] g,
    input logic [3:0] b,
    input logic       frame_tick,
    input logic       play
);

    // syncs only ever pulse in blanking
    a_de_off_in_sync: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (!hsync || !vsync) |-> !de)
        else $error("data enable high during a sync pulse");

    // single cycle tick
    a_tick_single: assert property (@(posedge clk_pix) disable iff (!arst_n)
        frame_tick |=> !frame_tick)
        else $error("frame tick high on two cycles in a row");

    a_black_in_blank: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !de |-> ((r == 4'h0) && (g == 4'h0) && (b == 4'h0)))
        else $error("colour present outside the picture");

    // serve released for good
    a_play_holds: assert property (@(posedge clk_pix) disable iff (!arst_n)
        play |=> play)
        else $error("play fell after the serve delay");

endmodule

bind pong_top pong_properties pong_properties_i (
    .clk_pix    (clk_pix),
    .arst_n     (arst_n),
    .hsync      (hsync),
    .vsync      (vsync),
    .de         (de),
    .r          (r),
    .g          (g),
    .b          (b),
    .frame_tick (frame_tick),
    .play       (play)
);

// ==== verif/pong_tb.sv ====
// pong testbench
// reset stimulus, reference game model, per-pixel output comparison
`timescale 1ns/100ps
`include "pong_config.svh"

module pong_tb;
    import pong_pkg::*;

    localparam int FRAME_CYCLES = `PONG_H_FULL * `PONG_V_FULL;
    localparam int RESET_CYCLES = 16;

    logic       clk_pix;
    logic       por_n;      // power-on reset
    logic       ext_rst_n;  // mid-run reset pulse
    logic       arst_n;
    logic       hsync;
    logic       vsync;
    logic       de;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    // compare state, also watched by the stimulus
    bit     aligned;     // counters locked to the output
    int     col;
    int     row;
    int     frame_no;    // frames since reset
    bit     prev_de;
    bit     rst_held;    // reset low at the previous falling edge too
    int     align_wait;
    int     de_run;      // length of current de pulse
    int     act_lines;   // de pulses this frame
    int     error_count;
    int     reset_line;  // line of the extra reset in frame 3
    video_t exp_px;

    assign arst_n = por_n && ext_rst_n;

    pong_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) pong_clk_gen_i (
        .clk_pix (clk_pix),
        .rst_n   (por_n)
    );

    pong_top pong_top_i (
        .clk_pix, .arst_n, .hsync, .vsync, .de, .r, .g, .b
    );

    // wrong value, report and end the run
    task automatic report_mismatch(input string msg);
        error_count++;
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test failures found");
        $fatal(1, "stopping on a timeout");
    endtask

    // expected output pixel at column sx, row sy of a frame counted from reset
    function automatic video_t expected_pixel(input int frame_idx, input int sx, input int sy);
        int     bx;
        int     by;
        int     pad_y;      // both paddles see the same ball
        bit     ball_left;
        bit     ball_up;
        int     steps;
        int     pad_mid;
        int     ball_mid;
        bit     hit;
        video_t v;
        bx        = `PONG_B_X0;
        by        = `PONG_B_Y0;
        pad_y     = `PONG_P_Y0;
        ball_left = 1'b0;  // right and down at serve
        ball_up   = 1'b0;
        steps     = frame_idx - `PONG_SERVE_FRAMES;  // ticks that move anything
        for (int i = 0; i < steps; i++) begin
            // paddle chases the ball as it was before this step
            pad_mid  = pad_y + `PONG_P_H / 2;
            ball_mid = by + `PONG_B_SIZE / 2;
            if (pad_mid + `PONG_P_SP / 2 < ball_mid) begin
                if (pad_y < `PONG_V_RES - `PONG_P_H - `PONG_P_SP / 2) begin
                    pad_y += `PONG_P_SP;
                end
            end else if (pad_mid > ball_mid + `PONG_P_SP / 2) begin
                if (pad_y > `PONG_P_SP) begin
                    pad_y -= `PONG_P_SP;
                end
            end
            if (bx >= `PONG_H_RES - `PONG_B_SPX - `PONG_B_SIZE) begin
                ball_left = 1'b1;  // off the right wall
            end else if (bx < `PONG_B_SPX) begin
                ball_left = 1'b0;
            end
            bx = ball_left ? bx - `PONG_B_SPX : bx + `PONG_B_SPX;
            if (by >= `PONG_V_RES - `PONG_B_SPY - `PONG_B_SIZE) begin
                ball_up = 1'b1;  // off the floor
            end else if (by < `PONG_B_SPY) begin
                ball_up = 1'b0;
            end
            by = ball_up ? by - `PONG_B_SPY : by + `PONG_B_SPY;
        end
        v.de    = (sx < `PONG_H_RES) && (sy < `PONG_V_RES);
        v.hsync = !((sx >= `PONG_HS_START) && (sx <= `PONG_HS_END));  // pins active low
        v.vsync = !((sy >= `PONG_VS_START) && (sy <= `PONG_VS_END));
        hit = (sx >= bx) && (sx < bx + `PONG_B_SIZE) && (sy >= by) && (sy < by + `PONG_B_SIZE);
        hit = hit || ((sx >= `PONG_P_OFFS) && (sx < `PONG_P_OFFS + `PONG_P_W)
                      && (sy >= pad_y) && (sy < pad_y + `PONG_P_H));
        hit = hit || ((sx >= `PONG_H_RES - `PONG_P_OFFS - `PONG_P_W)
                      && (sx < `PONG_H_RES - `PONG_P_OFFS)
                      && (sy >= pad_y) && (sy < pad_y + `PONG_P_H));
        v.rgb = (v.de && hit) ? 12'hfff : 12'h000;
        return v;
    endfunction

    // compare at the falling edge, outputs settled since the rising one
    always @(negedge clk_pix) begin
        if (!arst_n) begin
            if (rst_held) begin
                assert (hsync && vsync && !de && ({r, g, b} == 12'h000))
                else report_mismatch($sformatf("reset state: hs %b vs %b de %b rgb %h",
                                               hsync, vsync, de, {r, g, b}));
            end
            rst_held   = 1'b1;
            aligned    = 1'b0;
            frame_no   = 0;
            align_wait = 0;
        end else begin
            rst_held = 1'b0;
            if (!aligned) begin
                if (de && !prev_de) begin  // pixel 0,0 of frame 0
                    aligned   = 1'b1;
                    col       = 0;
                    row       = 0;
                    de_run    = 0;
                    act_lines = 0;
                end else begin
                    align_wait++;
                    if (align_wait > FRAME_CYCLES) begin
                        timeout_abort("first data enable after reset");
                    end
                end
            end
            if (aligned) begin
                exp_px = expected_pixel(frame_no, col, row);
                assert ({hsync, vsync, de, r, g, b} == exp_px)
                else report_mismatch($sformatf("col %0d row %0d frame %0d: got %h, expected %h",
                                               col, row, frame_no,
                                               {hsync, vsync, de, r, g, b}, exp_px));
                if (de) begin
                    if (!prev_de) begin
                        act_lines++;
                    end
                    de_run++;
                end else if (prev_de) begin
                    assert (de_run == `PONG_H_RES)
                    else report_mismatch($sformatf("row %0d: de high for %0d cycles",
                                                   row, de_run));
                    de_run = 0;
                end
                col++;
                if (col == `PONG_H_FULL) begin
                    col = 0;
                    row++;
                    if (row == `PONG_V_FULL) begin  // frame done
                        row = 0;
                        assert (act_lines == `PONG_V_RES)
                        else report_mismatch($sformatf("frame %0d: %0d active lines",
                                                       frame_no, act_lines));
                        act_lines = 0;
                        frame_no++;
                    end
                end
            end
        end
        prev_de = de;
    end

    // block until the compare counters reach a row of a frame
    task automatic wait_for_pixel(input int frame, input int line, input int limit,
                                  input string what);
        int cycles;
        cycles = 0;
        while (!(aligned && (frame_no == frame) && (row == line))) begin
            @(posedge clk_pix);
            cycles++;
            if (cycles > limit) begin
                timeout_abort(what);
            end
        end
    endtask

    initial begin
        ext_rst_n   = 1'b1;
        error_count = 0;
        void'($urandom(32'h29d5));
        reset_line = int'($urandom % `PONG_V_FULL);
        // game plays into frame 3, then a second reset
        wait_for_pixel(3, reset_line, 5 * FRAME_CYCLES, "reset line in frame 3");
        @(negedge clk_pix);
        ext_rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_pix);
        ext_rst_n <= 1'b1;
        // serve delay and motion again from the new frame 0
        wait_for_pixel(7, 0, 8 * FRAME_CYCLES, "end of frame 6 after the second reset");
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== pong_video.f ====
+incdir+source
source/pong_pkg.sv
source/display_timings.sv
source/game_control.sv
source/ball_motion.sv
source/paddle_ai.sv
source/pixel_compose.sv
source/pong_top.sv
verif/pong_clk_gen.sv
verif/pong_properties.sv
verif/pong_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the pong testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module pong_tb \
    -f pong_video.f \
    -o pong_sim

output=$(./obj_dir/pong_sim) || true
echo "$output"
if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
